/* cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

`define CPU_XLEN     32
`define CPU_NREGS    32
`define CPU_DMEM_AW  8              // data memory word address bits

// instruction fields
`define CPU_F_RD     4:0
`define CPU_F_RJ     9:5
`define CPU_F_RK     14:10
`define CPU_F_SI12   21:10
`define CPU_F_OP3R   31:15
`define CPU_F_OP2RI  31:22

// 3R opcodes in inst[31:15]
`define CPU_OP_ADD_W   17'h00020
`define CPU_OP_SUB_W   17'h00022
`define CPU_OP_SLT     17'h00024
`define CPU_OP_AND     17'h00029
`define CPU_OP_OR      17'h0002a
`define CPU_OP_XOR     17'h0002b

// 2RI12 opcodes in inst[31:22]
`define CPU_OP_ADDI_W  10'h00a
`define CPU_OP_LD_B    10'h0a0
`define CPU_OP_LD_H    10'h0a1
`define CPU_OP_LD_W    10'h0a2
`define CPU_OP_ST_W    10'h0a6
`define CPU_OP_LD_BU   10'h0a8
`define CPU_OP_LD_HU   10'h0a9

`endif

/* cpu_pkg.sv */
`include "cpu_config.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0]          word_t;
    typedef logic [$clog2(`CPU_NREGS)-1:0] reg_addr_t;
    typedef logic [`CPU_DMEM_AW-1:0]       dmem_addr_t;   // word address into data sram

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_t;

    typedef enum logic [2:0] {
        LD_NONE,
        LD_B,
        LD_H,
        LD_W,
        LD_BU,
        LD_HU
    } ld_kind_t;

    // decode -> execute
    typedef struct packed {
        word_t     pc;
        alu_op_t   alu_op;
        word_t     src1;            // forwarded rj
        word_t     src2;            // forwarded rk or sign-extended imm
        word_t     st_data;         // forwarded rd for st.w
        logic      rf_we;
        reg_addr_t rf_waddr;
        ld_kind_t  ld_kind;
        logic      is_store;
    } id_to_exe_t;

    typedef struct packed {
        word_t     pc;
        word_t     alu_result;
        logic      rf_we;
        reg_addr_t rf_waddr;
        ld_kind_t  ld_kind;
        logic [1:0] addr_low;       // byte offset within the word
    } exe_to_mem_t;

    typedef struct packed {
        word_t     pc;
        logic      rf_we;
        reg_addr_t rf_waddr;
        word_t     rf_wdata;
    } mem_to_wb_t;

    // bypass info from exe, mem and wb back to decode
    typedef struct packed {
        logic      valid_we;
        reg_addr_t waddr;
        word_t     wdata;
        logic      is_load;         // only exe sets this
    } fwd_t;

    typedef struct packed {
        word_t     pc;
        logic      rf_we;
        reg_addr_t rf_waddr;
        word_t     rf_wdata;
    } trace_t;

endpackage

/* regfile.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module regfile (
    input  logic               clk,
    input  cpu_pkg::reg_addr_t raddr1,
    output cpu_pkg::word_t     rdata1,
    input  cpu_pkg::reg_addr_t raddr2,
    output cpu_pkg::word_t     rdata2,
    input  logic               we,
    input  cpu_pkg::reg_addr_t waddr,
    input  cpu_pkg::word_t     wdata
);
    import cpu_pkg::*;

    word_t regs [1:`CPU_NREGS-1];   // no storage behind r0

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // combinational read, r0 hardwired to zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* id_stage.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module id_stage (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  inst_valid,
    input  cpu_pkg::word_t        inst_pc,
    input  cpu_pkg::word_t        inst,
    output logic                  inst_ready,
    output cpu_pkg::reg_addr_t    rf_raddr1,
    output cpu_pkg::reg_addr_t    rf_raddr2,
    input  cpu_pkg::word_t        rf_rdata1,
    input  cpu_pkg::word_t        rf_rdata2,
    input  cpu_pkg::fwd_t         exe_fwd,
    input  cpu_pkg::fwd_t         mem_fwd,
    input  cpu_pkg::fwd_t         wb_fwd,
    input  logic                  exe_allowin,
    output logic                  id_to_exe_valid,
    output cpu_pkg::id_to_exe_t   id_to_exe
);
    import cpu_pkg::*;

    logic      id_valid;
    logic      rst_done;            // keeps inst_ready low for the first cycle out of reset
    logic      id_ready_go;
    logic      id_allowin;
    logic      id_accept;
    word_t     id_pc;
    word_t     id_inst;

    reg_addr_t rd, rj, rk;
    word_t     imm;
    logic      is_3r, is_addi, is_load, is_store;
    logic      use_src1, use_src2;
    logic      rf_we;
    alu_op_t   alu_op;
    ld_kind_t  ld_kind;
    word_t     src1_val, src2_val;
    logic      load_use;

    // youngest writer wins, r0 never bypassed
    function automatic word_t fwd_pick(input reg_addr_t addr, input word_t rf_val,
                                       input fwd_t e, input fwd_t m, input fwd_t w);
        word_t v;
        v = rf_val;
        if (addr != '0) begin
            if (w.valid_we && w.waddr == addr) v = w.wdata;
            if (m.valid_we && m.waddr == addr) v = m.wdata;
            if (e.valid_we && e.waddr == addr) v = e.wdata;
        end
        return v;
    endfunction

    assign id_allowin      = ~id_valid | (id_ready_go & exe_allowin);
    assign inst_ready      = rst_done & id_allowin;
    assign id_accept       = inst_valid & inst_ready;
    assign id_to_exe_valid = id_valid & id_ready_go;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rst_done <= 1'b0;
            id_valid <= 1'b0;
        end else begin
            rst_done <= 1'b1;
            if (id_allowin) id_valid <= id_accept;
        end
    end

    always_ff @(posedge clk) begin
        if (id_accept) begin
            id_pc   <= inst_pc;
            id_inst <= inst;
        end
    end

    assign rd  = id_inst[`CPU_F_RD];
    assign rj  = id_inst[`CPU_F_RJ];
    assign rk  = id_inst[`CPU_F_RK];
    assign imm = {{20{id_inst[21]}}, id_inst[`CPU_F_SI12]};

    always_comb begin
        is_3r  = 1'b1;
        alu_op = ALU_ADD;           // loads and stores add base + imm
        case (id_inst[`CPU_F_OP3R])
            `CPU_OP_ADD_W: alu_op = ALU_ADD;
            `CPU_OP_SUB_W: alu_op = ALU_SUB;
            `CPU_OP_SLT:   alu_op = ALU_SLT;
            `CPU_OP_AND:   alu_op = ALU_AND;
            `CPU_OP_OR:    alu_op = ALU_OR;
            `CPU_OP_XOR:   alu_op = ALU_XOR;
            default:       is_3r  = 1'b0;
        endcase
        is_addi  = 1'b0;
        is_store = 1'b0;
        ld_kind  = LD_NONE;
        case (id_inst[`CPU_F_OP2RI])
            `CPU_OP_ADDI_W: is_addi  = 1'b1;
            `CPU_OP_LD_B:   ld_kind  = LD_B;
            `CPU_OP_LD_H:   ld_kind  = LD_H;
            `CPU_OP_LD_W:   ld_kind  = LD_W;
            `CPU_OP_LD_BU:  ld_kind  = LD_BU;
            `CPU_OP_LD_HU:  ld_kind  = LD_HU;
            `CPU_OP_ST_W:   is_store = 1'b1;
            default: ;                          // unknown op retires as a no-op
        endcase
    end

    assign is_load  = (ld_kind != LD_NONE);
    assign use_src1 = is_3r | is_addi | is_load | is_store;
    assign use_src2 = is_3r | is_store;
    assign rf_we    = (is_3r | is_addi | is_load) & (rd != '0);   // r0 writes dropped here

    assign rf_raddr1 = rj;
    assign rf_raddr2 = is_store ? rd : rk;     // st.w reads its data from rd

    assign src1_val = fwd_pick(rf_raddr1, rf_rdata1, exe_fwd, mem_fwd, wb_fwd);
    assign src2_val = fwd_pick(rf_raddr2, rf_rdata2, exe_fwd, mem_fwd, wb_fwd);

    // load still in exe, its data is not there yet
    assign load_use = exe_fwd.valid_we & exe_fwd.is_load & (exe_fwd.waddr != '0)
                    & ((use_src1 & (rf_raddr1 == exe_fwd.waddr))
                    |  (use_src2 & (rf_raddr2 == exe_fwd.waddr)));
    assign id_ready_go = ~load_use;

    always_comb begin
        id_to_exe.pc       = id_pc;
        id_to_exe.alu_op   = alu_op;
        id_to_exe.src1     = src1_val;
        id_to_exe.src2     = is_3r ? src2_val : imm;
        id_to_exe.st_data  = src2_val;
        id_to_exe.rf_we    = rf_we;
        id_to_exe.rf_waddr = rd;
        id_to_exe.ld_kind  = ld_kind;
        id_to_exe.is_store = is_store;
    end

endmodule

/* exe_stage.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module exe_stage (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  id_to_exe_valid,
    input  cpu_pkg::id_to_exe_t   id_to_exe,
    output logic                  exe_allowin,
    input  logic                  mem_allowin,
    output logic                  exe_to_mem_valid,
    output cpu_pkg::exe_to_mem_t  exe_to_mem,
    output cpu_pkg::fwd_t         exe_fwd,
    output logic                  data_sram_en,
    output logic [3:0]            data_sram_we,
    output cpu_pkg::dmem_addr_t   data_sram_addr,
    output cpu_pkg::word_t        data_sram_wdata
);
    import cpu_pkg::*;

    logic       exe_valid;
    logic       exe_ready_go;
    id_to_exe_t exe_r;
    word_t      alu_result;
    logic       is_load;

    assign exe_ready_go     = 1'b1;    // sram request always taken in one cycle
    assign exe_allowin      = ~exe_valid | (exe_ready_go & mem_allowin);
    assign exe_to_mem_valid = exe_valid & exe_ready_go;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            exe_valid <= 1'b0;
        end else if (exe_allowin) begin
            exe_valid <= id_to_exe_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (id_to_exe_valid && exe_allowin) begin
            exe_r <= id_to_exe;
        end
    end

    always_comb begin
        case (exe_r.alu_op)
            ALU_ADD: alu_result = exe_r.src1 + exe_r.src2;
            ALU_SUB: alu_result = exe_r.src1 - exe_r.src2;
            ALU_AND: alu_result = exe_r.src1 & exe_r.src2;
            ALU_OR:  alu_result = exe_r.src1 | exe_r.src2;
            ALU_XOR: alu_result = exe_r.src1 ^ exe_r.src2;
            ALU_SLT: alu_result = {31'b0, $signed(exe_r.src1) < $signed(exe_r.src2)};
            default: alu_result = '0;
        endcase
    end

    assign is_load = (exe_r.ld_kind != LD_NONE);

    // data comes back next cycle, while the load is in mem
    assign data_sram_en    = exe_valid & (is_load | exe_r.is_store);
    assign data_sram_we    = {4{exe_valid & exe_r.is_store}};     // st.w only, all lanes
    assign data_sram_addr  = alu_result[`CPU_DMEM_AW+1:2];
    assign data_sram_wdata = exe_r.st_data;

    always_comb begin
        exe_to_mem.pc         = exe_r.pc;
        exe_to_mem.alu_result = alu_result;
        exe_to_mem.rf_we      = exe_r.rf_we;
        exe_to_mem.rf_waddr   = exe_r.rf_waddr;
        exe_to_mem.ld_kind    = exe_r.ld_kind;
        exe_to_mem.addr_low   = alu_result[1:0];
    end

    assign exe_fwd.valid_we = exe_valid & exe_r.rf_we;
    assign exe_fwd.waddr    = exe_r.rf_waddr;
    assign exe_fwd.wdata    = alu_result;       // not the value yet for a load
    assign exe_fwd.is_load  = is_load;

endmodule

/* mem_stage.sv */
`timescale 1ns/1ps

module mem_stage (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  exe_to_mem_valid,
    input  cpu_pkg::exe_to_mem_t  exe_to_mem,
    output logic                  mem_allowin,
    input  logic                  wb_allowin,
    output logic                  mem_to_wb_valid,
    output cpu_pkg::mem_to_wb_t   mem_to_wb,
    output cpu_pkg::fwd_t         mem_fwd,
    input  cpu_pkg::word_t        data_sram_rdata
);
    import cpu_pkg::*;

    logic        mem_valid;
    logic        mem_ready_go;
    exe_to_mem_t mem_r;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    word_t       ld_result;
    word_t       rf_wdata;

    assign mem_ready_go    = 1'b1;
    assign mem_allowin     = ~mem_valid | (mem_ready_go & wb_allowin);
    assign mem_to_wb_valid = mem_valid & mem_ready_go;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_valid <= 1'b0;
        end else if (mem_allowin) begin
            mem_valid <= exe_to_mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (exe_to_mem_valid && mem_allowin) begin
            mem_r <= exe_to_mem;
        end
    end

    always_comb begin
        case (mem_r.addr_low)
            2'd0: ld_byte = data_sram_rdata[7:0];
            2'd1: ld_byte = data_sram_rdata[15:8];
            2'd2: ld_byte = data_sram_rdata[23:16];
            default: ld_byte = data_sram_rdata[31:24];
        endcase
    end

    assign ld_half = mem_r.addr_low[1] ? data_sram_rdata[31:16] : data_sram_rdata[15:0];

    always_comb begin
        case (mem_r.ld_kind)
            LD_B:    ld_result = {{24{ld_byte[7]}}, ld_byte};
            LD_BU:   ld_result = {24'b0, ld_byte};
            LD_H:    ld_result = {{16{ld_half[15]}}, ld_half};
            LD_HU:   ld_result = {16'b0, ld_half};
            default: ld_result = data_sram_rdata;           // ld.w
        endcase
    end

    assign rf_wdata = (mem_r.ld_kind == LD_NONE) ? mem_r.alu_result : ld_result;

    always_comb begin
        mem_to_wb.pc       = mem_r.pc;
        mem_to_wb.rf_we    = mem_r.rf_we;
        mem_to_wb.rf_waddr = mem_r.rf_waddr;
        mem_to_wb.rf_wdata = rf_wdata;
    end

    assign mem_fwd.valid_we = mem_valid & mem_r.rf_we;
    assign mem_fwd.waddr    = mem_r.rf_waddr;
    assign mem_fwd.wdata    = rf_wdata;     // load data already resolved here
    assign mem_fwd.is_load  = 1'b0;

endmodule

/* wb_stage.sv */
`timescale 1ns/1ps

module wb_stage (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  mem_to_wb_valid,
    input  cpu_pkg::mem_to_wb_t   mem_to_wb,
    output logic                  wb_allowin,
    output logic                  rf_we,
    output cpu_pkg::reg_addr_t    rf_waddr,
    output cpu_pkg::word_t        rf_wdata,
    output cpu_pkg::fwd_t         wb_fwd,
    output logic                  trace_valid,
    output cpu_pkg::trace_t       trace
);
    import cpu_pkg::*;

    logic       wb_valid;
    logic       wb_ready_go;
    mem_to_wb_t wb_r;

    assign wb_ready_go = 1'b1;                 // trace has no back-pressure
    assign wb_allowin  = ~wb_valid | wb_ready_go;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else if (wb_allowin) begin
            wb_valid <= mem_to_wb_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_to_wb_valid && wb_allowin) begin
            wb_r <= mem_to_wb;
        end
    end

    assign rf_we    = wb_valid & wb_r.rf_we;
    assign rf_waddr = wb_r.rf_waddr;
    assign rf_wdata = wb_r.rf_wdata;

    // rf write lands at the end of this cycle, so decode still needs the bypass
    assign wb_fwd.valid_we = rf_we;
    assign wb_fwd.waddr    = wb_r.rf_waddr;
    assign wb_fwd.wdata    = wb_r.rf_wdata;
    assign wb_fwd.is_load  = 1'b0;

    assign trace_valid    = wb_valid;
    assign trace.pc       = wb_r.pc;
    assign trace.rf_we    = wb_r.rf_we;
    assign trace.rf_waddr = wb_r.rf_waddr;
    assign trace.rf_wdata = wb_r.rf_wdata;

endmodule

/* cpu_core.sv */
`timescale 1ns/1ps

module cpu_core (
    input  logic                clk,
    input  logic                resetn,
    input  logic                inst_valid,
    input  cpu_pkg::word_t      inst_pc,
    input  cpu_pkg::word_t      inst,
    output logic                inst_ready,
    output logic                data_sram_en,
    output logic [3:0]          data_sram_we,
    output cpu_pkg::dmem_addr_t data_sram_addr,
    output cpu_pkg::word_t      data_sram_wdata,
    input  cpu_pkg::word_t      data_sram_rdata,
    output logic                trace_valid,
    output cpu_pkg::trace_t     trace
);
    import cpu_pkg::*;

    logic        id_to_exe_valid, exe_allowin;
    logic        exe_to_mem_valid, mem_allowin;
    logic        mem_to_wb_valid, wb_allowin;
    id_to_exe_t  id_to_exe;
    exe_to_mem_t exe_to_mem;
    mem_to_wb_t  mem_to_wb;
    fwd_t        exe_fwd, mem_fwd, wb_fwd;

    reg_addr_t   rf_raddr1, rf_raddr2, rf_waddr;
    word_t       rf_rdata1, rf_rdata2, rf_wdata;
    logic        rf_we;

    id_stage u_id (
        .clk, .resetn,
        .inst_valid, .inst_pc, .inst, .inst_ready,
        .rf_raddr1, .rf_raddr2, .rf_rdata1, .rf_rdata2,
        .exe_fwd, .mem_fwd, .wb_fwd,
        .exe_allowin, .id_to_exe_valid, .id_to_exe
    );

    exe_stage u_exe (
        .clk, .resetn,
        .id_to_exe_valid, .id_to_exe, .exe_allowin,
        .mem_allowin, .exe_to_mem_valid, .exe_to_mem, .exe_fwd,
        .data_sram_en, .data_sram_we, .data_sram_addr, .data_sram_wdata
    );

    mem_stage u_mem (
        .clk, .resetn,
        .exe_to_mem_valid, .exe_to_mem, .mem_allowin,
        .wb_allowin, .mem_to_wb_valid, .mem_to_wb, .mem_fwd,
        .data_sram_rdata
    );

    wb_stage u_wb (
        .clk, .resetn,
        .mem_to_wb_valid, .mem_to_wb, .wb_allowin,
        .rf_we, .rf_waddr, .rf_wdata, .wb_fwd,
        .trace_valid, .trace
    );

    regfile u_rf (
        .clk,
        .raddr1 (rf_raddr1),
        .rdata1 (rf_rdata1),
        .raddr2 (rf_raddr2),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

endmodule

/* tb_checker.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module tb_checker (
    input  logic            clk,
    input  logic            resetn,
    input  logic            inst_valid,
    input  logic            inst_ready,
    input  cpu_pkg::word_t  inst_pc,
    input  cpu_pkg::word_t  inst,
    input  logic            data_sram_en,
    input  logic            trace_valid,
    input  cpu_pkg::trace_t trace,
    input  logic [127:0]    test_name,
    output int              errors,
    output int              pending
);
    import cpu_pkg::*;

    word_t pc_q [$];                     // accepted, not yet retired
    word_t inst_q [$];
    word_t regs [`CPU_NREGS];
    word_t mem [1 << `CPU_DMEM_AW];
    int    rst_edges;
    logic  started;

    initial begin
        errors    = 0;
        pending   = 0;
        rst_edges = 0;
        started   = 1'b0;
        foreach (regs[i]) regs[i] = '0;
        foreach (mem[i]) mem[i] = '0;
    end

    task automatic check_field(input string field, input word_t exp, input word_t act);
        if (act !== exp) begin
            errors++;
            $display("Error %0s %0s expected %h actual %h", test_name, field, exp, act);
        end
    endtask

    // ISA model, one instruction at a time in program order
    task automatic run_model(input word_t w, output logic we, output reg_addr_t waddr,
                             output word_t wdata);
        reg_addr_t rd;
        word_t     a;
        word_t     b;
        word_t     imm;
        word_t     addr;
        word_t     lane;
        word_t     res;
        rd   = w[`CPU_F_RD];
        a    = regs[w[`CPU_F_RJ]];
        b    = regs[w[`CPU_F_RK]];
        imm  = {{20{w[21]}}, w[`CPU_F_SI12]};
        addr = a + imm;
        lane = mem[addr[`CPU_DMEM_AW+1:2]] >> (8 * addr[1:0]);   // addressed byte at bit 0
        we   = 1'b1;
        res  = '0;
        case (w[`CPU_F_OP3R])
            `CPU_OP_ADD_W: res = a + b;
            `CPU_OP_SUB_W: res = a - b;
            `CPU_OP_AND:   res = a & b;
            `CPU_OP_OR:    res = a | b;
            `CPU_OP_XOR:   res = a ^ b;
            `CPU_OP_SLT:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: begin
                case (w[`CPU_F_OP2RI])
                    `CPU_OP_ADDI_W: res = a + imm;
                    `CPU_OP_LD_B:   res = {{24{lane[7]}}, lane[7:0]};
                    `CPU_OP_LD_BU:  res = {24'b0, lane[7:0]};
                    `CPU_OP_LD_H:   res = {{16{lane[15]}}, lane[15:0]};
                    `CPU_OP_LD_HU:  res = {16'b0, lane[15:0]};
                    `CPU_OP_LD_W:   res = lane;
                    `CPU_OP_ST_W: begin
                        mem[addr[`CPU_DMEM_AW+1:2]] = regs[rd];
                        we = 1'b0;
                    end
                    default: we = 1'b0;              // unknown op, nothing written
                endcase
            end
        endcase
        if (rd == '0) we = 1'b0;
        if (we) regs[rd] = res;
        waddr = rd;
        wdata = res;
    endtask

    always @(posedge clk) begin
        logic      exp_we;
        reg_addr_t exp_waddr;
        word_t     exp_wdata;
        word_t     exp_pc;
        if (!resetn) begin
            rst_edges++;
            // first edge only clears the flops
            if (rst_edges > 1 && (trace_valid !== 1'b0 || data_sram_en !== 1'b0)) begin
                errors++;
                $display("%0s: trace or data sram active during reset", test_name);
            end
        end else begin
            if (inst_valid && inst_ready) begin
                pc_q.push_back(inst_pc);
                inst_q.push_back(inst);
                started = 1'b1;
            end
            if (!started && (trace_valid !== 1'b0 || data_sram_en !== 1'b0)) begin
                errors++;
                $display("%0s: trace or data sram active before any instruction", test_name);
            end else if (trace_valid) begin
                if (inst_q.size() == 0) begin
                    errors++;
                    $display("%0s: unexpected trace entry at pc %h", test_name, trace.pc);
                end else begin
                    exp_pc = pc_q.pop_front();
                    run_model(inst_q.pop_front(), exp_we, exp_waddr, exp_wdata);
                    check_field("pc", exp_pc, trace.pc);
                    check_field("rf_we", word_t'(exp_we), word_t'(trace.rf_we));
                    if (exp_we) begin
                        check_field("rf_waddr", word_t'(exp_waddr), word_t'(trace.rf_waddr));
                        check_field("rf_wdata", exp_wdata, trace.rf_wdata);
                    end
                end
            end
        end
        pending = inst_q.size();
    end

endmodule

/* tb_cpu.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module tb_cpu;
    import cpu_pkg::*;

    localparam int N_INIT     = `CPU_NREGS - 1;
    localparam int N_ALU      = 200;
    localparam int N_WORDS    = 4;
    localparam int N_LOAD     = N_WORDS * (28 + 1 + 13);   // build, store, 13 loads per word
    localparam int N_LU_PAIRS = 40;
    localparam int N_MIX      = 80;
    localparam int N_TOTAL    = N_INIT + N_ALU + N_LOAD + 2 * N_LU_PAIRS + N_MIX;
    localparam int LIMIT      = N_TOTAL * 3 + 200;

    logic         clk;
    logic         resetn;
    logic         inst_valid;
    word_t        inst_pc;
    word_t        inst;
    logic         inst_ready;
    logic         data_sram_en;
    logic [3:0]   data_sram_we;
    dmem_addr_t   data_sram_addr;
    word_t        data_sram_wdata;
    word_t        data_sram_rdata;
    logic         trace_valid;
    trace_t       trace;

    word_t        dmem [1 << `CPU_DMEM_AW];
    logic [127:0] test_name;
    int           errors;
    int           pending;
    int           err_base;
    int           pass_cnt;
    int           fail_cnt;
    int           cycles;
    int           seed_val;
    word_t        pc_next;

    cpu_core uut (
        .clk, .resetn,
        .inst_valid, .inst_pc, .inst, .inst_ready,
        .data_sram_en, .data_sram_we, .data_sram_addr, .data_sram_wdata, .data_sram_rdata,
        .trace_valid, .trace
    );

    tb_checker u_chk (
        .clk, .resetn, .inst_valid, .inst_ready, .inst_pc, .inst,
        .data_sram_en, .trace_valid, .trace, .test_name,
        .errors, .pending
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // sram model returns read data one cycle after the request
    always @(posedge clk) begin
        if (data_sram_en) begin
            for (int b = 0; b < 4; b++) begin
                if (data_sram_we[b]) dmem[data_sram_addr][8*b +: 8] <= data_sram_wdata[8*b +: 8];
            end
            data_sram_rdata <= dmem[data_sram_addr];
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    // run limit from the total instruction count
    initial begin
        wait (cycles > LIMIT);
        $display("timeout after %0d cycles, %0d accepted instructions never retired",
                 cycles, pending);
        $display("TEST FAIL");
        $finish;
    end

    function automatic word_t enc_3r(input logic [16:0] op, input reg_addr_t rd,
                                     input reg_addr_t rj, input reg_addr_t rk);
        return {op, rk, rj, rd};
    endfunction

    function automatic word_t enc_2ri(input logic [9:0] op, input reg_addr_t rd,
                                      input reg_addr_t rj, input logic [11:0] imm);
        return {op, imm, rj, rd};
    endfunction

    function automatic reg_addr_t pool_reg();
        return reg_addr_t'($urandom_range(1, 4));     // small pool makes hazards common
    endfunction

    function automatic word_t rand_alu(input reg_addr_t rd, input reg_addr_t rj,
                                       input reg_addr_t rk);
        case ($urandom_range(0, 6))
            0: return enc_2ri(`CPU_OP_ADDI_W, rd, rj, 12'($urandom));
            1: return enc_3r(`CPU_OP_ADD_W, rd, rj, rk);
            2: return enc_3r(`CPU_OP_SUB_W, rd, rj, rk);
            3: return enc_3r(`CPU_OP_AND, rd, rj, rk);
            4: return enc_3r(`CPU_OP_OR, rd, rj, rk);
            5: return enc_3r(`CPU_OP_XOR, rd, rj, rk);
            default: return enc_3r(`CPU_OP_SLT, rd, rj, rk);
        endcase
    endfunction

    // any op10 outside the subset; 3R ops all have op10 == 0
    function automatic word_t rand_unknown();
        logic [9:0] op;
        do op = 10'($urandom);
        while (op == 10'h0 || op == `CPU_OP_ADDI_W || op == `CPU_OP_LD_B || op == `CPU_OP_LD_H
               || op == `CPU_OP_LD_W || op == `CPU_OP_ST_W || op == `CPU_OP_LD_BU
               || op == `CPU_OP_LD_HU);
        return {op, 22'($urandom)};
    endfunction

    task automatic push(input word_t w);
        inst_valid <= 1'b1;
        inst_pc    <= pc_next;
        inst       <= w;
        pc_next     = pc_next + 32'd4;
        @(posedge clk);
        while (inst_ready !== 1'b1) @(posedge clk);
        inst_valid <= 1'b0;
    endtask

    // 32-bit constant built from addi and eight doublings per byte
    task automatic build_word(input reg_addr_t r, input word_t v);
        push(enc_2ri(`CPU_OP_ADDI_W, r, 5'd0, {4'b0, v[31:24]}));
        for (int k = 2; k >= 0; k--) begin
            repeat (8) push(enc_3r(`CPU_OP_ADD_W, r, r, r));
            push(enc_2ri(`CPU_OP_ADDI_W, r, r, {4'b0, v[8*k +: 8]}));
        end
    endtask

    task automatic start_test(input logic [127:0] name);
        test_name = name;
        err_base  = errors;
    endtask

    task automatic finish_test();
        do @(negedge clk);
        while (pending != 0);
        repeat (4) @(negedge clk);                 // catch stray trace entries
        if (errors == err_base) begin
            pass_cnt++;
            $display("%0s: passed", test_name);
        end else begin
            fail_cnt++;
            $display("%0s: failed with %0d errors", test_name, errors - err_base);
        end
        @(posedge clk);
    endtask

    task automatic alu_test();
        start_test("alu_fwd");
        for (int r = 1; r < `CPU_NREGS; r++) begin
            push(enc_2ri(`CPU_OP_ADDI_W, reg_addr_t'(r), 5'd0, 12'($urandom)));
        end
        repeat (N_ALU) push(rand_alu(pool_reg(), pool_reg(), pool_reg()));
        finish_test();
    endtask

    task automatic load_test();
        logic [11:0] a;
        start_test("load_width");
        for (int i = 0; i < N_WORDS; i++) begin
            build_word(5'd5, $urandom);
            push(enc_2ri(`CPU_OP_ST_W, 5'd5, 5'd0, 12'h040 + 12'(4 * i)));
        end
        for (int i = 0; i < N_WORDS; i++) begin
            a = 12'h040 + 12'(4 * i);
            for (int k = 0; k < 4; k++) begin
                push(enc_2ri(`CPU_OP_LD_B, reg_addr_t'($urandom_range(6, 9)), 5'd0, a + 12'(k)));
                push(enc_2ri(`CPU_OP_LD_BU, reg_addr_t'($urandom_range(6, 9)), 5'd0, a + 12'(k)));
            end
            for (int k = 0; k < 4; k += 2) begin
                push(enc_2ri(`CPU_OP_LD_H, reg_addr_t'($urandom_range(6, 9)), 5'd0, a + 12'(k)));
                push(enc_2ri(`CPU_OP_LD_HU, reg_addr_t'($urandom_range(6, 9)), 5'd0, a + 12'(k)));
            end
            push(enc_2ri(`CPU_OP_LD_W, reg_addr_t'($urandom_range(6, 9)), 5'd0, a));
        end
        finish_test();
    endtask

    task automatic load_use_test();
        logic [9:0]  op;
        logic [11:0] a;
        reg_addr_t   rx;
        start_test("load_use");
        repeat (N_LU_PAIRS) begin
            rx = reg_addr_t'($urandom_range(5, 8));
            a  = 12'h040 + 12'(4 * $urandom_range(0, N_WORDS - 1));
            case ($urandom_range(0, 4))
                0: begin op = `CPU_OP_LD_B;  a = a + 12'($urandom_range(0, 3)); end
                1: begin op = `CPU_OP_LD_BU; a = a + 12'($urandom_range(0, 3)); end
                2: begin op = `CPU_OP_LD_H;  a = a + 12'(2 * $urandom_range(0, 1)); end
                3: begin op = `CPU_OP_LD_HU; a = a + 12'(2 * $urandom_range(0, 1)); end
                default: op = `CPU_OP_LD_W;
            endcase
            push(enc_2ri(op, rx, 5'd0, a));
            case ($urandom_range(0, 3))        // consumer right behind the load
                0: push(enc_3r(`CPU_OP_ADD_W, pool_reg(), rx, pool_reg()));
                1: push(enc_3r(`CPU_OP_SUB_W, pool_reg(), pool_reg(), rx));
                2: push(enc_2ri(`CPU_OP_ADDI_W, pool_reg(), rx, 12'($urandom)));
                default: push(enc_2ri(`CPU_OP_ST_W, rx, 5'd0,
                                      12'h080 + 12'(4 * $urandom_range(0, 7))));
            endcase
        end
        finish_test();
    endtask

    task automatic mix_test();
        start_test("bubbles_r0");
        repeat (N_MIX) begin
            repeat ($urandom_range(0, 2)) @(posedge clk);
            case ($urandom_range(0, 4))
                0: push(enc_2ri(`CPU_OP_ADDI_W, 5'd0, pool_reg(), 12'($urandom)));
                1: push(rand_alu(5'd0, pool_reg(), pool_reg()));
                2: push(rand_unknown());
                3: push(rand_alu(pool_reg(), 5'd0, pool_reg()));
                default: push(rand_alu(pool_reg(), pool_reg(), 5'd0));
            endcase
        end
        finish_test();
    endtask

    initial begin
        seed_val        = $urandom(32'hb6432d3b);
        resetn          = 1'b0;
        inst_valid      = 1'b0;
        inst_pc         = '0;
        inst            = '0;
        data_sram_rdata = '0;
        pc_next         = 32'h1c00_0000;
        pass_cnt        = 0;
        fail_cnt        = 0;
        cycles          = 0;
        foreach (dmem[i]) dmem[i] = '0;
        start_test("reset");
        repeat (8) @(posedge clk);
        resetn <= 1'b1;
        repeat (10) @(posedge clk);                // idle with nothing sent
        finish_test();
        alu_test();
        load_test();
        load_use_test();
        mix_test();
        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+.
cpu_pkg.sv
regfile.sv
id_stage.sv
exe_stage.sv
mem_stage.sv
wb_stage.sv
cpu_core.sv
tb_checker.sv
tb_cpu.sv
